//--- logic/skdecode_cfg.svh
/*
 * Size and arithmetic constants for the secret-key decode engine
 */
`ifndef SKDECODE_CFG_SVH
`define SKDECODE_CFG_SVH

// Polynomials in s1, and in each of s2 and t0
`define SKDEC_L 4
`define SKDEC_K 4

// Coefficients per polynomial
`define SKDEC_N 32

// Field modulus and the s1/s2 eta
`define SKDEC_Q 8380417
`define SKDEC_ETA 2

// Key and coefficient memory word address
`define SKDEC_ADDR_W 14

// t0 gather buffer, three 64-bit reads deep
`define SKDEC_T0_BUF_W 192

`endif

//--- logic/skdecode_pkg.sv
/*
 * Types shared by the decode engine: memory words, port requests,
 * FSM state encodings and the modular subtract used by both unpackers
 */
`include "skdecode_cfg.svh"

package skdecode_pkg;

    typedef logic [`SKDEC_ADDR_W-1:0] mem_addr_t;
    typedef logic [31:0]              key_word_t;
    typedef logic [23:0]              coeff_t;

    // Four coefficients, coefficient 0 in the low bits
    typedef logic [95:0]              coeff_word_t;

    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } mem_rw_mode_e;

    typedef struct packed {
        mem_addr_t    addr;
        mem_rw_mode_e rw_mode;
    } mem_req_t;

    typedef enum logic [2:0] {
        RD_IDLE, RD_S1, RD_S2, RD_T0, RD_STAGE
    } skdec_rd_state_e;

    typedef enum logic [2:0] {
        WR_IDLE, WR_S1, WR_S2, WR_T0, WR_STAGE
    } skdec_wr_state_e;

    // offset - field mod q, for any field below q
    function automatic coeff_t sub_mod_q(input coeff_t offset, input coeff_t field);
        coeff_t diff;
        diff = offset - field;
        if (field > offset)
            diff = diff + coeff_t'(`SKDEC_Q);
        return diff;
    endfunction

endpackage

//--- logic/skdecode_ctrl.sv
/*
 * Decode sequencing: key read FSM with stall pacing, trailing write FSM,
 * phase counters, coefficient write steering and the sticky error flag
 */
`timescale 1ns/1ns
`include "skdecode_cfg.svh"

module skdecode_ctrl (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize,
    input  logic                            skdecode_enable,
    input  skdecode_pkg::mem_addr_t         src_base_addr,
    input  skdecode_pkg::mem_addr_t         dest_base_addr,
    input  logic                            s1s2_valid,
    input  logic                            s1s2_error,
    input  logic                            t0_valid,
    input  logic                            t0_buf_stall,
    input  skdecode_pkg::coeff_word_t [1:0] s1s2_data,
    input  skdecode_pkg::coeff_word_t       t0_data,
    output skdecode_pkg::mem_req_t          kmem_a_rd_req,
    output skdecode_pkg::mem_req_t          kmem_b_rd_req,
    output skdecode_pkg::mem_req_t          mem_a_wr_req,
    output skdecode_pkg::mem_req_t          mem_b_wr_req,
    output skdecode_pkg::coeff_word_t       mem_a_wr_data,
    output skdecode_pkg::coeff_word_t       mem_b_wr_data,
    output logic                            s1s2_enable,
    output logic                            s1s2_buf_stall,
    output logic                            t0_enable,
    output logic                            kmem_rd_valid,
    output logic                            skdecode_done,
    output logic                            skdecode_error
);
    import skdecode_pkg::*;

    // s1/s2 phases count one output per cycle, stall slots included
    localparam int S1_OUTS  = `SKDEC_L * `SKDEC_N / 8;
    localparam int S2_OUTS  = `SKDEC_K * `SKDEC_N / 8;
    // t0 counts double-word reads, which give K*N/4 outputs
    localparam int T0_READS = `SKDEC_K * `SKDEC_N * 13 / 64;
    localparam int CNT_W    = $clog2(S1_OUTS + S2_OUTS + T0_READS);

    skdec_rd_state_e  rd_state, rd_state_nxt;
    skdec_wr_state_e  wr_state, wr_state_nxt;

    // Index of the phase in progress: 0 s1, 1 s2, 2 t0
    logic [1:0]       phase;
    logic [CNT_W-1:0] rd_count;
    logic [CNT_W-1:0] rd_last;
    mem_addr_t        rd_addr;
    mem_addr_t        wr_addr;

    logic start;
    logic s1s2_mode;
    logic s1s2_stall_nxt;
    logic t0_rd;
    logic rd_a;
    logic rd_b;
    logic cnt_step;
    logic phase_end;
    logic stage_meet;
    logic wr_s1s2;
    logic wr_t0;
    logic wr_en;

    // ------------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------------
    always_comb begin
        start          = skdecode_enable && (wr_state == WR_IDLE);
        s1s2_mode      = (rd_state == RD_S1) || (rd_state == RD_S2);
        // Every fourth s1/s2 slot drains the gather register
        s1s2_stall_nxt = s1s2_mode && (rd_count[1:0] == 2'd3);
        t0_rd          = (rd_state == RD_T0) && !t0_buf_stall;
        rd_a           = (s1s2_mode && !s1s2_stall_nxt && !rd_addr[0]) || t0_rd;
        rd_b           = (s1s2_mode && !s1s2_stall_nxt && rd_addr[0]) || t0_rd;
        cnt_step       = s1s2_mode || t0_rd;

        unique case (rd_state)
            RD_S1:   rd_last = CNT_W'(S1_OUTS - 1);
            RD_S2:   rd_last = CNT_W'(S2_OUTS - 1);
            default: rd_last = CNT_W'(T0_READS - 1);
        endcase

        phase_end  = cnt_step && (rd_count == rd_last);
        stage_meet = (wr_state == WR_STAGE);
    end

    always_comb begin
        rd_state_nxt = rd_state;
        unique case (rd_state)
            RD_IDLE:
                if (start)
                    rd_state_nxt = RD_S1;
            RD_S1, RD_S2, RD_T0:
                if (phase_end)
                    rd_state_nxt = RD_STAGE;
            RD_STAGE:
                if (stage_meet)
                    rd_state_nxt = (phase == 2'd0) ? RD_S2 :
                                   (phase == 2'd1) ? RD_T0 : RD_IDLE;
            default:
                rd_state_nxt = RD_IDLE;
        endcase
    end

    // ------------------------------------------------------------------------
    // Write side, trails the reads by the unpack latency
    // ------------------------------------------------------------------------
    always_comb begin
        wr_state_nxt = wr_state;
        unique case (wr_state)
            WR_IDLE:
                if (start)
                    wr_state_nxt = WR_S1;
            WR_S1, WR_S2:
                if (rd_state == RD_STAGE && !s1s2_valid)
                    wr_state_nxt = WR_STAGE;
            WR_T0:
                if (rd_state == RD_STAGE && !t0_valid)
                    wr_state_nxt = WR_STAGE;
            WR_STAGE:
                wr_state_nxt = (phase == 2'd0) ? WR_S2 :
                               (phase == 2'd1) ? WR_T0 : WR_IDLE;
            default:
                wr_state_nxt = WR_IDLE;
        endcase
    end

    // s1/s2 pairs fill an even/odd word pair, t0 goes by address parity
    always_comb begin
        wr_s1s2 = (wr_state == WR_S1) || (wr_state == WR_S2);
        wr_t0   = (wr_state == WR_T0);
        wr_en   = (wr_s1s2 && s1s2_valid) || (wr_t0 && t0_valid);

        mem_a_wr_req.addr    = wr_addr;
        mem_a_wr_req.rw_mode = (wr_en && !(wr_t0 && wr_addr[0])) ? RW_WRITE : RW_IDLE;
        mem_b_wr_req.addr    = wr_t0 ? wr_addr : wr_addr + mem_addr_t'(1);
        mem_b_wr_req.rw_mode = (wr_en && !(wr_t0 && !wr_addr[0])) ? RW_WRITE : RW_IDLE;
        mem_a_wr_data        = wr_t0 ? t0_data : s1s2_data[0];
        mem_b_wr_data        = wr_t0 ? t0_data : s1s2_data[1];

        kmem_a_rd_req.addr    = rd_addr;
        kmem_a_rd_req.rw_mode = rd_a ? RW_READ : RW_IDLE;
        kmem_b_rd_req.addr    = (rd_state == RD_T0) ? rd_addr + mem_addr_t'(1) : rd_addr;
        kmem_b_rd_req.rw_mode = rd_b ? RW_READ : RW_IDLE;

        skdecode_done = (wr_state == WR_IDLE);
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            rd_state       <= RD_IDLE;
            wr_state       <= WR_IDLE;
            phase          <= '0;
            rd_count       <= '0;
            rd_addr        <= '0;
            wr_addr        <= '0;
            kmem_rd_valid  <= 1'b0;
            s1s2_enable    <= 1'b0;
            s1s2_buf_stall <= 1'b0;
            t0_enable      <= 1'b0;
            skdecode_error <= 1'b0;
        end else begin
            rd_state <= rd_state_nxt;
            wr_state <= wr_state_nxt;

            if (start)
                phase <= '0;
            else if (stage_meet)
                phase <= phase + 2'd1;

            if (rd_state == RD_IDLE || rd_state == RD_STAGE)
                rd_count <= '0;
            else if (cnt_step)
                rd_count <= rd_count + 1'b1;

            if (start)
                rd_addr <= src_base_addr;
            else if (rd_a || rd_b)
                rd_addr <= rd_addr + ((rd_state == RD_T0) ? mem_addr_t'(2) : mem_addr_t'(1));

            if (start)
                wr_addr <= dest_base_addr;
            else if (wr_en)
                wr_addr <= wr_addr + (wr_t0 ? mem_addr_t'(1) : mem_addr_t'(2));

            // Aligned with the read data one cycle later
            kmem_rd_valid  <= rd_a || rd_b;
            s1s2_enable    <= s1s2_mode;
            s1s2_buf_stall <= s1s2_stall_nxt;
            t0_enable      <= (rd_state == RD_T0);

            if (start)
                skdecode_error <= 1'b0;
            else if (s1s2_error)
                skdecode_error <= 1'b1;
        end
    end

    // s1/s2 words come from one bank at a time and each phase starts on bank a
    a_s1s2_one_bank: assert property (@(posedge clk) disable iff (!reset_n)
        s1s2_mode |-> !(kmem_a_rd_req.rw_mode == RW_READ && kmem_b_rd_req.rw_mode == RW_READ)
            && (rd_count != '0 || kmem_a_rd_req.rw_mode == RW_READ));

    // No unpack output arrives while the write side is idle
    a_no_idle_write: assert property (@(posedge clk) disable iff (!reset_n)
        (wr_state == WR_IDLE) |-> (!s1s2_valid && !t0_valid));

endmodule

//--- logic/s1s2_unpack.sv
/*
 * s1/s2 unpacker: 32-bit key words in, eight eta-centred coefficients out
 */
`timescale 1ns/1ns
`include "skdecode_cfg.svh"

module s1s2_unpack (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize,
    input  logic                            s1s2_enable,
    input  logic                            s1s2_buf_stall,
    input  logic                            kmem_rd_valid,
    input  skdecode_pkg::key_word_t         kmem_a_rd_data,
    input  skdecode_pkg::key_word_t         kmem_b_rd_data,
    output logic                            s1s2_valid,
    output skdecode_pkg::coeff_word_t [1:0] s1s2_data,
    output logic                            s1s2_error
);
    import skdecode_pkg::*;

    localparam int ETA = `SKDEC_ETA;

    logic [63:0]  gather;
    logic [63:0]  gather_in;
    logic [6:0]   fill;
    logic [6:0]   fill_in;
    logic         bank_b;
    logic         take;
    logic         emit;
    logic         bad;
    coeff_t [7:0] coeffs;

    always_comb begin
        take      = s1s2_enable && kmem_rd_valid;
        gather_in = gather;
        fill_in   = fill;
        if (take) begin
            // Words alternate banks, starting on bank a
            gather_in = gather | ({32'h0, bank_b ? kmem_b_rd_data : kmem_a_rd_data} << fill);
            fill_in   = fill + 7'd32;
        end

        // Stall slots have no new word but still drain 24 bits
        emit = s1s2_enable && (take || s1s2_buf_stall) && (fill_in >= 7'd24);

        bad = 1'b0;
        for (int i = 0; i < 8; i++) begin
            coeffs[i] = sub_mod_q(coeff_t'(ETA), coeff_t'(gather_in[3*i +: 3]));
            bad       = bad || (gather_in[3*i +: 3] > 3'(2 * ETA));
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            gather     <= '0;
            fill       <= '0;
            bank_b     <= 1'b0;
            s1s2_valid <= 1'b0;
            s1s2_error <= 1'b0;
        end else begin
            bank_b     <= s1s2_enable && (bank_b ^ take);
            gather     <= emit ? gather_in >> 24 : gather_in;
            fill       <= emit ? fill_in - 7'd24 : fill_in;
            s1s2_valid <= emit;
            s1s2_error <= emit && bad;
        end
    end

    always_ff @(posedge clk) begin
        if (emit)
            s1s2_data <= coeffs;
    end

    a_fill_bound: assert property (@(posedge clk) disable iff (!reset_n)
        fill_in <= 7'd64);

endmodule

//--- logic/t0_unpack.sv
/*
 * t0 unpacker: 64-bit bank pairs into a bit buffer, four 13-bit
 * coefficients out per cycle, with a stall before the buffer fills
 */
`timescale 1ns/1ns
`include "skdecode_cfg.svh"

module t0_unpack (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      t0_enable,
    input  logic                      kmem_rd_valid,
    input  skdecode_pkg::key_word_t   kmem_a_rd_data,
    input  skdecode_pkg::key_word_t   kmem_b_rd_data,
    output logic                      t0_valid,
    output skdecode_pkg::coeff_word_t t0_data,
    output logic                      t0_buf_stall
);
    import skdecode_pkg::*;

    localparam int BUF_W  = `SKDEC_T0_BUF_W;
    localparam int FILL_W = $clog2(BUF_W + 1);

    logic [BUF_W-1:0]  bit_buf;
    logic [BUF_W-1:0]  bit_buf_in;
    logic [FILL_W-1:0] fill;
    logic [FILL_W-1:0] fill_in;
    logic              take;
    logic              emit;
    coeff_t [3:0]      coeffs;

    always_comb begin
        take       = t0_enable && kmem_rd_valid;
        bit_buf_in = bit_buf;
        fill_in    = fill;
        if (take) begin
            bit_buf_in = bit_buf | (BUF_W'({kmem_b_rd_data, kmem_a_rd_data}) << fill);
            fill_in    = fill + FILL_W'(64);
        end

        // Keeps draining after the phase ends until the buffer is empty
        emit = (fill_in >= FILL_W'(52));

        for (int i = 0; i < 4; i++)
            coeffs[i] = sub_mod_q(coeff_t'(4096), coeff_t'(bit_buf_in[13*i +: 13]));

        // A read issued now lands after the one already in flight
        t0_buf_stall = (int'(fill) + (take ? 64 : 0) + 64) > BUF_W;
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            bit_buf  <= '0;
            fill     <= '0;
            t0_valid <= 1'b0;
        end else begin
            bit_buf  <= emit ? bit_buf_in >> 52 : bit_buf_in;
            fill     <= emit ? fill_in - FILL_W'(52) : fill_in;
            t0_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (emit)
            t0_data <= coeffs;
    end

    // Holds only if the controller honours the stall
    a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        int'(fill_in) <= BUF_W);

endmodule

//--- logic/skdecode_top.sv
/*
 * Secret-key decode engine top: controller and the two unpackers
 */
`timescale 1ns/1ns

module skdecode_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      skdecode_enable,
    input  skdecode_pkg::mem_addr_t   src_base_addr,
    input  skdecode_pkg::mem_addr_t   dest_base_addr,
    output skdecode_pkg::mem_req_t    kmem_a_rd_req,
    output skdecode_pkg::mem_req_t    kmem_b_rd_req,
    input  skdecode_pkg::key_word_t   kmem_a_rd_data,
    input  skdecode_pkg::key_word_t   kmem_b_rd_data,
    output skdecode_pkg::mem_req_t    mem_a_wr_req,
    output skdecode_pkg::mem_req_t    mem_b_wr_req,
    output skdecode_pkg::coeff_word_t mem_a_wr_data,
    output skdecode_pkg::coeff_word_t mem_b_wr_data,
    output logic                      skdecode_done,
    output logic                      skdecode_error
);
    import skdecode_pkg::*;

    // Controller to unpack strobes
    logic s1s2_enable;
    logic s1s2_buf_stall;
    logic t0_enable;
    logic kmem_rd_valid;

    // Unpack results back to the controller
    logic              s1s2_valid;
    logic              s1s2_error;
    coeff_word_t [1:0] s1s2_data;
    logic              t0_valid;
    logic              t0_buf_stall;
    coeff_word_t       t0_data;

    skdecode_ctrl ctrl_i (.*);

    // Both unpackers see every key read and filter by their enable
    s1s2_unpack s1s2_unpack_i (.*);

    t0_unpack t0_unpack_i (.*);

endmodule

//--- bench/skdecode_tb.sv
/*
 * Decode engine testbench: key bank and coefficient memory models,
 * reference decode, result checks and a watchdog
 */
`timescale 1ns/1ns
`include "skdecode_cfg.svh"

module skdecode_tb;
    import skdecode_pkg::*;

    localparam int L             = `SKDEC_L;
    localparam int K             = `SKDEC_K;
    localparam int N             = `SKDEC_N;
    localparam int MEM_WORDS     = 1 << `SKDEC_ADDR_W;
    localparam int S12_COEFFS    = (L + K) * N;
    localparam int S12_BITS      = S12_COEFFS * 3;
    localparam int KEY_WORDS     = (S12_BITS + K * N * 13) / 32;
    localparam int OUT_WORDS     = (L + 2 * K) * N / 4;
    localparam int DECODE_CYCLES = 4 * (L + 2 * K) * N;
    // Seven decodes plus reset and the idle stretch after zeroize
    localparam int WATCHDOG_CYCLES = 7 * DECODE_CYCLES + 16 + 1000;

    logic        clk;
    logic        reset_n;
    logic        zeroize;
    logic        skdecode_enable;
    mem_addr_t   src_base_addr;
    mem_addr_t   dest_base_addr;
    mem_req_t    kmem_a_rd_req;
    mem_req_t    kmem_b_rd_req;
    key_word_t   kmem_a_rd_data;
    key_word_t   kmem_b_rd_data;
    mem_req_t    mem_a_wr_req;
    mem_req_t    mem_b_wr_req;
    coeff_word_t mem_a_wr_data;
    coeff_word_t mem_b_wr_data;
    logic        skdecode_done;
    logic        skdecode_error;

    key_word_t   key_bank_a [MEM_WORDS/2];
    key_word_t   key_bank_b [MEM_WORDS/2];
    coeff_word_t coeff_mem [MEM_WORDS];
    int          wr_count [MEM_WORDS];
    key_word_t   key_words [KEY_WORDS];
    mem_req_t    rd_req_a;
    mem_req_t    rd_req_b;
    mem_addr_t   cur_src;
    mem_addr_t   cur_dest;
    int          total_writes;
    int          errors;
    string       test_name;
    int unsigned seed_ret;

    skdecode_top dut_i (.*);

    always #2 clk = ~clk;

    // ------------------------------------------------------------------------
    // Memory models
    // ------------------------------------------------------------------------

    // Key banks, one cycle read latency
    always @(posedge clk) begin
        rd_req_a = kmem_a_rd_req;
        rd_req_b = kmem_b_rd_req;
        #1;
        if (rd_req_a.rw_mode == RW_READ) begin
            if (rd_req_a.addr[0]) begin
                $display("%s: bank a read at odd address %0d", test_name, rd_req_a.addr);
                errors++;
            end
            kmem_a_rd_data = key_bank_a[rd_req_a.addr >> 1];
        end
        if (rd_req_b.rw_mode == RW_READ) begin
            if (!rd_req_b.addr[0]) begin
                $display("%s: bank b read at even address %0d", test_name, rd_req_b.addr);
                errors++;
            end
            kmem_b_rd_data = key_bank_b[rd_req_b.addr >> 1];
        end
    end

    task automatic record_write(input mem_req_t req, input coeff_word_t data,
                                input logic port_b);
        if (req.addr[0] !== port_b) begin
            $display("%s: address %0d written on the wrong port", test_name, req.addr);
            errors++;
        end
        coeff_mem[req.addr] = data;
        wr_count[req.addr]++;
        total_writes++;
    endtask

    always @(posedge clk) begin
        if (mem_a_wr_req.rw_mode == RW_WRITE)
            record_write(mem_a_wr_req, mem_a_wr_data, 1'b0);
        if (mem_b_wr_req.rw_mode == RW_WRITE)
            record_write(mem_b_wr_req, mem_b_wr_data, 1'b1);
    end

    // ------------------------------------------------------------------------
    // Key image and reference decode
    // ------------------------------------------------------------------------
    function automatic int key_field(input int pos, input int width);
        int value;
        int b;
        value = 0;
        for (b = 0; b < width; b++)
            if (key_words[(pos + b) / 32][(pos + b) % 32])
                value = value | (1 << b);
        return value;
    endfunction

    task automatic put_field(input int pos, input int width, input int value);
        int b;
        for (b = 0; b < width; b++)
            key_words[(pos + b) / 32][(pos + b) % 32] = value[b];
    endtask

    // s1/s2 fields in 0..4, one field of 6 placed in s1 when bad is set
    task automatic make_key(input logic bad);
        int f;
        for (f = 0; f < S12_COEFFS; f++)
            put_field(3 * f, 3, int'($urandom % 5));
        for (f = 0; f < K * N; f++)
            put_field(S12_BITS + 13 * f, 13, int'($urandom % 8192));
        if (bad)
            put_field(3 * int'($urandom % (L * N)), 3, 6);
    endtask

    function automatic coeff_word_t ref_decode(input int word_idx);
        coeff_word_t word;
        int          c;
        int          j;
        int          value;
        for (j = 0; j < 4; j++) begin
            c = 4 * word_idx + j;
            if (c < S12_COEFFS)
                value = `SKDEC_ETA - key_field(3 * c, 3);
            else
                value = 4096 - key_field(S12_BITS + 13 * (c - S12_COEFFS), 13);
            if (value < 0)
                value = value + `SKDEC_Q;
            word[24 * j +: 24] = value[23:0];
        end
        return word;
    endfunction

    task automatic load_key(input mem_addr_t base);
        int k;
        int w;
        for (k = 0; k < KEY_WORDS; k++) begin
            w = int'(base) + k;
            if (w % 2 == 0)
                key_bank_a[w / 2] = key_words[k];
            else
                key_bank_b[w / 2] = key_words[k];
        end
    endtask

    task automatic clear_writes();
        int a;
        for (a = 0; a < MEM_WORDS; a++) begin
            coeff_mem[a] = '0;
            wr_count[a]  = 0;
        end
        total_writes = 0;
    endtask

    // New even bases that differ from the previous decode
    task automatic pick_bases();
        mem_addr_t src;
        mem_addr_t dest;
        do begin
            src  = mem_addr_t'(($urandom % (MEM_WORDS - KEY_WORDS - 2)) & ~32'd1);
            dest = mem_addr_t'(($urandom % (MEM_WORDS - OUT_WORDS - 2)) & ~32'd1);
        end while (src == cur_src || dest == cur_dest);
        cur_src  = src;
        cur_dest = dest;
        load_key(cur_src);
        clear_writes();
    endtask

    // ------------------------------------------------------------------------
    // Decode control and checks
    // ------------------------------------------------------------------------
    task automatic start_decode();
        @(posedge clk);
        #1;
        src_base_addr   = cur_src;
        dest_base_addr  = cur_dest;
        skdecode_enable = 1'b1;
        @(posedge clk);
        #1;
        skdecode_enable = 1'b0;
        if (skdecode_done !== 1'b0) begin
            $display("%s: skdecode_done stayed high after the start strobe", test_name);
            errors++;
        end
        if (skdecode_error !== 1'b0) begin
            $display("ERROR %s: skdecode_error after start expected 0 actual %b",
                     test_name, skdecode_error);
            errors++;
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (skdecode_done !== 1'b1 && cycles < DECODE_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (skdecode_done !== 1'b1) begin
            $display("%s: decode did not finish in %0d cycles", test_name, DECODE_CYCLES);
            errors++;
        end
    endtask

    task automatic check_writes(input logic expect_error);
        coeff_word_t expected;
        int          i;
        int          a;
        for (i = 0; i < OUT_WORDS; i++) begin
            a        = int'(cur_dest) + i;
            expected = ref_decode(i);
            if (wr_count[a] != 1) begin
                $display("%s: address %0d written %0d times, not once", test_name, a,
                         wr_count[a]);
                errors++;
            end else if (coeff_mem[a] !== expected) begin
                $display("ERROR %s: word %0d expected %h actual %h", test_name, i,
                         expected, coeff_mem[a]);
                errors++;
            end
        end
        for (a = 0; a < MEM_WORDS; a++)
            if ((a < int'(cur_dest) || a >= int'(cur_dest) + OUT_WORDS) && wr_count[a] != 0) begin
                $display("%s: stray write to address %0d", test_name, a);
                errors++;
            end
        if (skdecode_error !== expect_error) begin
            $display("ERROR %s: skdecode_error expected %b actual %b", test_name,
                     expect_error, skdecode_error);
            errors++;
        end
    endtask

    task automatic decode_and_check(input logic bad);
        make_key(bad);
        pick_bases();
        start_decode();
        wait_done();
        check_writes(bad);
    endtask

    task automatic zeroize_mid_decode();
        int snapshot;
        make_key(1'b0);
        pick_bases();
        start_decode();
        repeat (30) @(posedge clk);
        #1;
        if (skdecode_done !== 1'b0) begin
            $display("%s: decode ended before zeroize was applied", test_name);
            errors++;
        end
        zeroize = 1'b1;
        @(posedge clk);
        #1;
        zeroize = 1'b0;
        if (skdecode_done !== 1'b1) begin
            $display("ERROR %s: skdecode_done expected 1 actual %b", test_name, skdecode_done);
            errors++;
        end
        snapshot = total_writes;
        repeat (20) begin
            @(posedge clk);
            #1;
            if (skdecode_done !== 1'b1) begin
                $display("%s: skdecode_done dropped after zeroize", test_name);
                errors++;
            end
        end
        if (total_writes != snapshot) begin
            $display("%s: %0d writes after zeroize", test_name, total_writes - snapshot);
            errors++;
        end
    endtask

    initial begin
        int w;
        seed_ret        = $urandom(32'h8d40_1e35);
        clk             = 1'b0;
        reset_n         = 1'b0;
        zeroize         = 1'b0;
        skdecode_enable = 1'b0;
        src_base_addr   = '0;
        dest_base_addr  = '0;
        kmem_a_rd_data  = '0;
        kmem_b_rd_data  = '0;
        cur_src         = '1;
        cur_dest        = '1;
        errors          = 0;
        test_name       = "reset";
        for (w = 0; w < MEM_WORDS; w++)
            if (w % 2 == 0)
                key_bank_a[w / 2] = key_word_t'(w) * 32'h9e37_79b9;
            else
                key_bank_b[w / 2] = key_word_t'(w) * 32'h9e37_79b9;
        clear_writes();

        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;
        if (skdecode_done !== 1'b1 || skdecode_error !== 1'b0 ||
            kmem_a_rd_req.rw_mode !== RW_IDLE || kmem_b_rd_req.rw_mode !== RW_IDLE ||
            mem_a_wr_req.rw_mode !== RW_IDLE || mem_b_wr_req.rw_mode !== RW_IDLE) begin
            $display("%s: outputs not in their idle state after reset", test_name);
            errors++;
        end

        test_name = "full_decode";
        decode_and_check(1'b0);
        test_name = "bad_field";
        decode_and_check(1'b1);
        test_name = "error_clear";
        decode_and_check(1'b0);
        test_name = "zeroize";
        zeroize_mid_decode();
        test_name = "after_zeroize";
        decode_and_check(1'b0);
        test_name = "back_to_back";
        decode_and_check(1'b0);
        decode_and_check(1'b0);

        $display("Decode tests finished with %0d errors", errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
        $display("Errors found");
        $finish;
    end

endmodule

//--- skdecode_top.f
+incdir+logic
logic/skdecode_pkg.sv
logic/skdecode_ctrl.sv
logic/s1s2_unpack.sv
logic/t0_unpack.sv
logic/skdecode_top.sv
bench/skdecode_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the decode engine testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module skdecode_tb -f skdecode_top.f \
    --Mdir obj_dir -o skdecode_sim > build.log 2>&1 &&
./obj_dir/skdecode_sim > sim.log 2>&1 ||
{ echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -qx "No errors" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }
